// ==== common/scope_pkg.sv ====
/*
 * shared definitions for the scope configuration block
 * widths, value types, register offsets and reset values,
 * the register-select enum and the bus write-word union
 */
package scope_pkg;

  localparam int N_CH      = 2;
  localparam int DW        = 14;
  localparam int RSZ       = 14;
  localparam int DEC_W     = 17;
  localparam int DLY_W     = 32;
  localparam int TRG_SRC_W = 4;
  localparam int ADDR_W    = 20;

  typedef logic signed [DW-1:0]    adc_word_t;
  typedef logic [DEC_W-1:0]        dec_t;
  typedef logic [DLY_W-1:0]        dly_t;
  typedef logic [TRG_SRC_W-1:0]    trg_src_t;

  // write word seen whole, or as one byte lane per channel
  typedef union packed {
    logic [31:0]     word;
    logic [3:0][7:0] lane;
  } sys_word_u;

  typedef enum logic [4:0] {
    CTRL, TRG_SRC, TRESH0, TRESH1, DLY0, DEC0, DLY1, DEC1, HYST0, HYST1,
    AVG_EN, WP_CUR0, WP_TRIG0, WP_CUR1, WP_TRIG1, TRIG_CLR, NONE
  } reg_sel_e;

  // register map, low address bits
  localparam logic [ADDR_W-1:0] ADDR_CTRL     = 20'h00000;
  localparam logic [ADDR_W-1:0] ADDR_TRG_SRC  = 20'h00004;
  localparam logic [ADDR_W-1:0] ADDR_TRESH0   = 20'h00008;
  localparam logic [ADDR_W-1:0] ADDR_TRESH1   = 20'h0000C;
  localparam logic [ADDR_W-1:0] ADDR_DLY0     = 20'h00010;
  localparam logic [ADDR_W-1:0] ADDR_DEC0     = 20'h00014;
  localparam logic [ADDR_W-1:0] ADDR_DLY1     = 20'h00110;
  localparam logic [ADDR_W-1:0] ADDR_DEC1     = 20'h00114;
  localparam logic [ADDR_W-1:0] ADDR_HYST0    = 20'h00020;
  localparam logic [ADDR_W-1:0] ADDR_HYST1    = 20'h00024;
  localparam logic [ADDR_W-1:0] ADDR_AVG_EN   = 20'h00028;
  localparam logic [ADDR_W-1:0] ADDR_WP_CUR0  = 20'h00018;
  localparam logic [ADDR_W-1:0] ADDR_WP_TRIG0 = 20'h0001C;
  localparam logic [ADDR_W-1:0] ADDR_WP_CUR1  = 20'h00118;
  localparam logic [ADDR_W-1:0] ADDR_WP_TRIG1 = 20'h0011C;
  localparam logic [ADDR_W-1:0] ADDR_TRIG_CLR = 20'h00094;

  // bit positions inside a control lane
  localparam int CTRL_ARM_BIT   = 0;
  localparam int CTRL_RST_BIT   = 1;
  localparam int CTRL_KEEP_BIT  = 3;
  localparam int CTRL_INDEP_BIT = 5;

  localparam trg_src_t TRG_SW_CODE = 4'd1;

  localparam adc_word_t TRESH_RST0 = 14'sd5000;
  localparam adc_word_t TRESH_RST1 = -14'sd5000;
  localparam adc_word_t HYST_RST   = 14'sd20;
  localparam dec_t      DEC_RST    = 17'd1;
  localparam dly_t      DLY_RST    = 32'd0;

endpackage

// ==== common/scope_access_if.sv ====
/*
 * one decoded bus access, passed from the decode stage
 * to the register and readback stages
 */
`timescale 1ns/1ps

interface scope_access_if
  import scope_pkg::*;
();

  // wr or rd is a single-cycle strobe, sel and wdata valid with it
  logic      wr;
  logic      rd;
  reg_sel_e  sel;
  sys_word_u wdata;

  modport producer (
    output wr, rd, sel, wdata
  );

  modport consumer (
    input wr, rd, sel, wdata
  );

endinterface

// ==== common/scope_cfg_if.sv ====
/*
 * stored per-channel settings, before channel following,
 * from the register stage to the readback stage
 */
`timescale 1ns/1ps

interface scope_cfg_if
  import scope_pkg::*;
();

  adc_word_t [N_CH-1:0] tresh;
  adc_word_t [N_CH-1:0] hyst;
  dly_t      [N_CH-1:0] dly;
  dec_t      [N_CH-1:0] dec;
  logic      [N_CH-1:0] avg_en;

  modport source (
    output tresh, hyst, dly, dec, avg_en
  );

  modport sink (
    input tresh, hyst, dly, dec, avg_en
  );

endinterface

// ==== design/scope_decode.sv ====
/*
 * bus decode stage
 * maps the address to a register select and registers the access
 */
`timescale 1ns/1ps

module scope_decode
  import scope_pkg::*;
(
  input  logic              adc_clk_i,
  input  logic              adc_rstn_i,
  input  logic [ADDR_W-1:0] sys_addr_i,
  input  logic [31:0]       sys_wdata_i,
  input  logic              sys_wen_i,
  input  logic              sys_ren_i,
  scope_access_if.producer  acc_o
);

  reg_sel_e sel_d;

  always_comb begin
    case (sys_addr_i)
      ADDR_CTRL:     sel_d = CTRL;
      ADDR_TRG_SRC:  sel_d = TRG_SRC;
      ADDR_TRESH0:   sel_d = TRESH0;
      ADDR_TRESH1:   sel_d = TRESH1;
      ADDR_DLY0:     sel_d = DLY0;
      ADDR_DEC0:     sel_d = DEC0;
      ADDR_DLY1:     sel_d = DLY1;
      ADDR_DEC1:     sel_d = DEC1;
      ADDR_HYST0:    sel_d = HYST0;
      ADDR_HYST1:    sel_d = HYST1;
      ADDR_AVG_EN:   sel_d = AVG_EN;
      ADDR_WP_CUR0:  sel_d = WP_CUR0;
      ADDR_WP_TRIG0: sel_d = WP_TRIG0;
      ADDR_WP_CUR1:  sel_d = WP_CUR1;
      ADDR_WP_TRIG1: sel_d = WP_TRIG1;
      ADDR_TRIG_CLR: sel_d = TRIG_CLR;
      default:       sel_d = NONE;
    endcase
  end

  // strobes
  always_ff @(posedge adc_clk_i) begin
    if (!adc_rstn_i) begin
      acc_o.wr <= 1'b0;
      acc_o.rd <= 1'b0;
    end else begin
      acc_o.wr <= sys_wen_i;
      acc_o.rd <= sys_ren_i;
    end
  end

  // select and data only matter while a strobe is high
  always_ff @(posedge adc_clk_i) begin
    acc_o.sel        <= sel_d;
    acc_o.wdata.word <= sys_wdata_i;
  end

  a_no_rd_wr_clash : assert property (@(posedge adc_clk_i) disable iff (!adc_rstn_i)
    !(sys_wen_i && sys_ren_i));

endmodule

// ==== scope_regs/scope_regs.sv ====
/*
 * register stage
 * per-channel settings and levels, command pulses
 * and channel 1 following channel 0 outside independent mode
 */
`timescale 1ns/1ps

module scope_regs
  import scope_pkg::*;
(
  input  logic                 adc_clk_i,
  input  logic                 adc_rstn_i,
  scope_access_if.consumer     acc_i,
  scope_cfg_if.source          cfg_o,
  output logic     [N_CH-1:0]  adc_arm_do_o,
  output logic     [N_CH-1:0]  adc_rst_do_o,
  output logic     [N_CH-1:0]  adc_trig_sw_o,
  output logic     [N_CH-1:0]  trig_dis_clr_o,
  output logic     [N_CH-1:0]  new_trg_src_o,
  output logic     [N_CH-1:0]  adc_we_keep_o,
  output logic     [N_CH-1:0]  indep_mode_o,
  output trg_src_t [N_CH-1:0]  trg_src_o,
  output adc_word_t [N_CH-1:0] set_tresh_o,
  output adc_word_t [N_CH-1:0] set_hyst_o,
  output dly_t     [N_CH-1:0]  set_dly_o,
  output dec_t     [N_CH-1:0]  set_dec_o,
  output logic     [N_CH-1:0]  set_dec1_o,
  output logic     [N_CH-1:0]  set_avg_en_o
);

  logic [N_CH-1:0][7:0] lane;
  logic                 wr_ctrl, wr_trg, wr_avg, wr_clr;
  logic [N_CH-1:0]      arm_q, rst_q, trig_sw_q, dis_clr_q, new_trg_q;
  logic [N_CH-1:0]      keep_q, indep_q, avg_q, own_ch;
  trg_src_t  [N_CH-1:0] trg_src_q;
  adc_word_t [N_CH-1:0] tresh_q, hyst_q;
  dly_t      [N_CH-1:0] dly_q;
  dec_t      [N_CH-1:0] dec_q;

  assign lane    = acc_i.wdata.lane[N_CH-1:0];
  assign wr_ctrl = acc_i.wr && (acc_i.sel == CTRL);
  assign wr_trg  = acc_i.wr && (acc_i.sel == TRG_SRC);
  assign wr_avg  = acc_i.wr && (acc_i.sel == AVG_EN);
  assign wr_clr  = acc_i.wr && (acc_i.sel == TRIG_CLR);

  // word-wide settings, one register per address
  always_ff @(posedge adc_clk_i) begin
    if (!adc_rstn_i) begin
      tresh_q[0] <= TRESH_RST0;
      tresh_q[1] <= TRESH_RST1;
      hyst_q     <= {N_CH{HYST_RST}};
      dly_q      <= {N_CH{DLY_RST}};
      dec_q      <= {N_CH{DEC_RST}};
    end else if (acc_i.wr) begin
      case (acc_i.sel)
        TRESH0: tresh_q[0] <= acc_i.wdata.word[DW-1:0];
        TRESH1: tresh_q[1] <= acc_i.wdata.word[DW-1:0];
        HYST0:  hyst_q[0]  <= acc_i.wdata.word[DW-1:0];
        HYST1:  hyst_q[1]  <= acc_i.wdata.word[DW-1:0];
        DLY0:   dly_q[0]   <= acc_i.wdata.word[DLY_W-1:0];
        DLY1:   dly_q[1]   <= acc_i.wdata.word[DLY_W-1:0];
        DEC0:   dec_q[0]   <= acc_i.wdata.word[DEC_W-1:0];
        DEC1:   dec_q[1]   <= acc_i.wdata.word[DEC_W-1:0];
        default: ;
      endcase
    end
  end

  // lane-decoded pulses and levels
  always_ff @(posedge adc_clk_i) begin
    if (!adc_rstn_i) begin
      arm_q     <= '0;
      rst_q     <= '0;
      trig_sw_q <= '0;
      new_trg_q <= '0;
      dis_clr_q <= '0;
      keep_q    <= '0;
      indep_q   <= '0;
      avg_q     <= '0;
      trg_src_q <= '0;
    end else begin
      for (int i = 0; i < N_CH; i++) begin
        arm_q[i]     <= wr_ctrl && lane[i][CTRL_ARM_BIT];
        rst_q[i]     <= wr_ctrl && lane[i][CTRL_RST_BIT];
        trig_sw_q[i] <= wr_trg && (lane[i][TRG_SRC_W-1:0] == TRG_SW_CODE);
        new_trg_q[i] <= wr_trg && (|lane[i][TRG_SRC_W-1:0]);
        dis_clr_q[i] <= wr_clr && lane[i][0];
        // an all-zero lane leaves the channel's mode untouched
        if (wr_ctrl && (|lane[i])) begin
          keep_q[i]  <= lane[i][CTRL_KEEP_BIT];
          indep_q[i] <= lane[i][CTRL_INDEP_BIT];
        end
        if (wr_trg && (|lane[i][TRG_SRC_W-1:0]))
          trg_src_q[i] <= lane[i][TRG_SRC_W-1:0];
        if (wr_avg)
          avg_q[i] <= lane[i][0];
      end
    end
  end

  // channel 0 always uses its own values
  assign own_ch = indep_q | N_CH'(1);

  always_comb begin
    for (int i = 0; i < N_CH; i++) begin
      adc_arm_do_o[i]   = own_ch[i] ? arm_q[i]     : arm_q[0];
      adc_rst_do_o[i]   = own_ch[i] ? rst_q[i]     : rst_q[0];
      adc_trig_sw_o[i]  = own_ch[i] ? trig_sw_q[i] : trig_sw_q[0];
      trig_dis_clr_o[i] = own_ch[i] ? dis_clr_q[i] : dis_clr_q[0];
      new_trg_src_o[i]  = own_ch[i] ? new_trg_q[i] : new_trg_q[0];
      adc_we_keep_o[i]  = own_ch[i] ? keep_q[i]    : keep_q[0];
      trg_src_o[i]      = own_ch[i] ? trg_src_q[i] : trg_src_q[0];
      set_dly_o[i]      = own_ch[i] ? dly_q[i]     : dly_q[0];
      set_dec_o[i]      = own_ch[i] ? dec_q[i]     : dec_q[0];
      set_avg_en_o[i]   = own_ch[i] ? avg_q[i]     : avg_q[0];
      set_dec1_o[i]     = (set_dec_o[i] == dec_t'(1));
    end
  end

  // thresholds and hysteresis are never shared
  assign set_tresh_o  = tresh_q;
  assign set_hyst_o   = hyst_q;
  assign indep_mode_o = indep_q;

  assign cfg_o.tresh  = tresh_q;
  assign cfg_o.hyst   = hyst_q;
  assign cfg_o.dly    = dly_q;
  assign cfg_o.dec    = dec_q;
  assign cfg_o.avg_en = avg_q;

  a_sw_trig_is_new_src : assert property (@(posedge adc_clk_i) disable iff (!adc_rstn_i)
    (adc_trig_sw_o & ~new_trg_src_o) == '0);

endmodule

// ==== design/scope_readback.sv ====
/*
 * readback stage
 * acks every access and muxes settings, status and pointers
 */
`timescale 1ns/1ps

module scope_readback
  import scope_pkg::*;
(
  input  logic                      adc_clk_i,
  input  logic                      adc_rstn_i,
  scope_access_if.consumer          acc_i,
  scope_cfg_if.sink                 cfg_i,
  input  logic [31:0]               adc_state_i,
  input  logic [31:0]               trg_state_i,
  input  logic [N_CH-1:0][RSZ-1:0]  adc_wp_cur_i,
  input  logic [N_CH-1:0][RSZ-1:0]  adc_wp_trig_i,
  output logic [31:0]               sys_rdata_o,
  output logic                      sys_ack_o,
  output logic                      sys_err_o
);

  logic [31:0] avg_word;
  logic [31:0] rdata_d;

  // one enable bit at the bottom of each lane
  always_comb begin
    avg_word = '0;
    for (int i = 0; i < N_CH; i++)
      avg_word[8*i] = cfg_i.avg_en[i];
  end

  // zero-extended, thresholds included
  always_comb begin
    case (acc_i.sel)
      CTRL:     rdata_d = adc_state_i;
      TRG_SRC:  rdata_d = trg_state_i;
      TRESH0:   rdata_d = {{32-DW{1'b0}}, cfg_i.tresh[0]};
      TRESH1:   rdata_d = {{32-DW{1'b0}}, cfg_i.tresh[1]};
      HYST0:    rdata_d = {{32-DW{1'b0}}, cfg_i.hyst[0]};
      HYST1:    rdata_d = {{32-DW{1'b0}}, cfg_i.hyst[1]};
      DLY0:     rdata_d = cfg_i.dly[0];
      DLY1:     rdata_d = cfg_i.dly[1];
      DEC0:     rdata_d = {{32-DEC_W{1'b0}}, cfg_i.dec[0]};
      DEC1:     rdata_d = {{32-DEC_W{1'b0}}, cfg_i.dec[1]};
      AVG_EN:   rdata_d = avg_word;
      WP_CUR0:  rdata_d = {{32-RSZ{1'b0}}, adc_wp_cur_i[0]};
      WP_TRIG0: rdata_d = {{32-RSZ{1'b0}}, adc_wp_trig_i[0]};
      WP_CUR1:  rdata_d = {{32-RSZ{1'b0}}, adc_wp_cur_i[1]};
      WP_TRIG1: rdata_d = {{32-RSZ{1'b0}}, adc_wp_trig_i[1]};
      default:  rdata_d = '0;
    endcase
  end

  always_ff @(posedge adc_clk_i) begin
    if (!adc_rstn_i) begin
      sys_ack_o <= 1'b0;
      sys_err_o <= 1'b0;
    end else begin
      sys_ack_o <= acc_i.wr || acc_i.rd;
      sys_err_o <= 1'b0;
    end
  end

  always_ff @(posedge adc_clk_i) begin
    sys_rdata_o <= rdata_d;
  end

endmodule

// ==== design/scope_cfg.sv ====
/*
 * scope configuration top level
 * decode, register and readback stages on the system bus
 */
`timescale 1ns/1ps

module scope_cfg
  import scope_pkg::*;
(
  input  logic                      adc_clk_i,
  input  logic                      adc_rstn_i,
  // system bus
  input  logic [ADDR_W-1:0]         sys_addr_i,
  input  logic [31:0]               sys_wdata_i,
  input  logic                      sys_wen_i,
  input  logic                      sys_ren_i,
  output logic [31:0]               sys_rdata_o,
  output logic                      sys_ack_o,
  output logic                      sys_err_o,
  // acquisition status
  input  logic [31:0]               adc_state_i,
  input  logic [31:0]               trg_state_i,
  input  logic [N_CH-1:0][RSZ-1:0]  adc_wp_cur_i,
  input  logic [N_CH-1:0][RSZ-1:0]  adc_wp_trig_i,
  // per-channel controls
  output logic      [N_CH-1:0]      adc_arm_do_o,
  output logic      [N_CH-1:0]      adc_rst_do_o,
  output logic      [N_CH-1:0]      adc_trig_sw_o,
  output logic      [N_CH-1:0]      trig_dis_clr_o,
  output logic      [N_CH-1:0]      new_trg_src_o,
  output logic      [N_CH-1:0]      adc_we_keep_o,
  output logic      [N_CH-1:0]      indep_mode_o,
  output trg_src_t  [N_CH-1:0]      trg_src_o,
  output adc_word_t [N_CH-1:0]      set_tresh_o,
  output adc_word_t [N_CH-1:0]      set_hyst_o,
  output dly_t      [N_CH-1:0]      set_dly_o,
  output dec_t      [N_CH-1:0]      set_dec_o,
  output logic      [N_CH-1:0]      set_dec1_o,
  output logic      [N_CH-1:0]      set_avg_en_o
);

  scope_access_if acc_if ();
  scope_cfg_if    cfg_if ();

  scope_decode u_decode (
    .adc_clk_i   (adc_clk_i),
    .adc_rstn_i  (adc_rstn_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .acc_o       (acc_if.producer)
  );

  scope_regs u_regs (
    .adc_clk_i      (adc_clk_i),
    .adc_rstn_i     (adc_rstn_i),
    .acc_i          (acc_if.consumer),
    .cfg_o          (cfg_if.source),
    .adc_arm_do_o   (adc_arm_do_o),
    .adc_rst_do_o   (adc_rst_do_o),
    .adc_trig_sw_o  (adc_trig_sw_o),
    .trig_dis_clr_o (trig_dis_clr_o),
    .new_trg_src_o  (new_trg_src_o),
    .adc_we_keep_o  (adc_we_keep_o),
    .indep_mode_o   (indep_mode_o),
    .trg_src_o      (trg_src_o),
    .set_tresh_o    (set_tresh_o),
    .set_hyst_o     (set_hyst_o),
    .set_dly_o      (set_dly_o),
    .set_dec_o      (set_dec_o),
    .set_dec1_o     (set_dec1_o),
    .set_avg_en_o   (set_avg_en_o)
  );

  scope_readback u_readback (
    .adc_clk_i     (adc_clk_i),
    .adc_rstn_i    (adc_rstn_i),
    .acc_i         (acc_if.consumer),
    .cfg_i         (cfg_if.sink),
    .adc_state_i   (adc_state_i),
    .trg_state_i   (trg_state_i),
    .adc_wp_cur_i  (adc_wp_cur_i),
    .adc_wp_trig_i (adc_wp_trig_i),
    .sys_rdata_o   (sys_rdata_o),
    .sys_ack_o     (sys_ack_o),
    .sys_err_o     (sys_err_o)
  );

  // each bus strobe comes back as an ack two cycles later
  a_ack_latency : assert property (@(posedge adc_clk_i) disable iff (!adc_rstn_i)
    sys_ack_o == $past(sys_wen_i || sys_ren_i, 2));

endmodule

// ==== sim/scope_ref_model.svh ====
/*
 * reference model of the scope configuration block
 * stored settings and levels, lane-decoded command pulses,
 * channel following and the expected readback word
 */
`ifndef SCOPE_REF_MODEL_SVH
`define SCOPE_REF_MODEL_SVH

  adc_word_t       m_tresh [N_CH];
  adc_word_t       m_hyst  [N_CH];
  dly_t            m_dly   [N_CH];
  dec_t            m_dec   [N_CH];
  trg_src_t        m_trg   [N_CH];
  logic [N_CH-1:0] m_avg;
  logic [N_CH-1:0] m_keep;
  logic [N_CH-1:0] m_indep;

  // expected results of the access issued two cycles back
  logic            x_ack;
  logic            x_rd;
  logic [31:0]     x_rdata;
  logic [N_CH-1:0] x_arm;
  logic [N_CH-1:0] x_rst;
  logic [N_CH-1:0] x_sw;
  logic [N_CH-1:0] x_new;
  logic [N_CH-1:0] x_clr;

  task automatic model_reset();
    m_tresh[0] = TRESH_RST0;
    m_tresh[1] = TRESH_RST1;
    for (int ch = 0; ch < N_CH; ch++) begin
      m_hyst[ch] = HYST_RST;
      m_dly[ch]  = '0;
      m_dec[ch]  = DEC_RST;
      m_trg[ch]  = '0;
    end
    m_avg   = '0;
    m_keep  = '0;
    m_indep = '0;
    x_ack   = 1'b0;
    x_rd    = 1'b0;
    x_rdata = '0;
    x_arm   = '0;
    x_rst   = '0;
    x_sw    = '0;
    x_new   = '0;
    x_clr   = '0;
  endtask

  // channel whose values a channel shows
  function automatic int src_ch(input int ch);
    return (ch == 0 || m_indep[ch]) ? ch : 0;
  endfunction

  function automatic logic [N_CH-1:0] follow(input logic [N_CH-1:0] v);
    logic [N_CH-1:0] f;
    for (int ch = 0; ch < N_CH; ch++)
      f[ch] = v[src_ch(ch)];
    return f;
  endfunction

  function automatic logic [N_CH-1:0] exp_dec1();
    logic [N_CH-1:0] f;
    for (int ch = 0; ch < N_CH; ch++)
      f[ch] = (m_dec[src_ch(ch)] == dec_t'(1));
    return f;
  endfunction

  function automatic logic [31:0] read_value(input logic [ADDR_W-1:0] addr,
      input logic [31:0] st_adc, input logic [31:0] st_trg,
      input logic [N_CH-1:0][RSZ-1:0] wp_cur, input logic [N_CH-1:0][RSZ-1:0] wp_trig);
    logic [31:0] v;
    v = '0;
    case (addr)
      ADDR_CTRL:     v = st_adc;
      ADDR_TRG_SRC:  v = st_trg;
      ADDR_TRESH0:   v[DW-1:0] = m_tresh[0];
      ADDR_TRESH1:   v[DW-1:0] = m_tresh[1];
      ADDR_HYST0:    v[DW-1:0] = m_hyst[0];
      ADDR_HYST1:    v[DW-1:0] = m_hyst[1];
      ADDR_DLY0:     v = m_dly[0];
      ADDR_DLY1:     v = m_dly[1];
      ADDR_DEC0:     v[DEC_W-1:0] = m_dec[0];
      ADDR_DEC1:     v[DEC_W-1:0] = m_dec[1];
      ADDR_WP_CUR0:  v[RSZ-1:0] = wp_cur[0];
      ADDR_WP_TRIG0: v[RSZ-1:0] = wp_trig[0];
      ADDR_WP_CUR1:  v[RSZ-1:0] = wp_cur[1];
      ADDR_WP_TRIG1: v[RSZ-1:0] = wp_trig[1];
      ADDR_AVG_EN: begin
        for (int ch = 0; ch < N_CH; ch++)
          v[8*ch] = m_avg[ch];
      end
      default: ;
    endcase
    return v;
  endfunction

  // read sees the state before this access, then a write is applied
  task automatic model_access(input logic wr, input logic rd, input logic [ADDR_W-1:0] addr,
      input sys_word_u d, input logic [31:0] st_adc, input logic [31:0] st_trg,
      input logic [N_CH-1:0][RSZ-1:0] wp_cur, input logic [N_CH-1:0][RSZ-1:0] wp_trig);
    logic [7:0] ln;
    trg_src_t   nib;
    x_ack   = wr || rd;
    x_rd    = rd;
    x_rdata = read_value(addr, st_adc, st_trg, wp_cur, wp_trig);
    x_arm   = '0;
    x_rst   = '0;
    x_sw    = '0;
    x_new   = '0;
    x_clr   = '0;
    if (wr) begin
      case (addr)
        ADDR_TRESH0: m_tresh[0] = d.word[DW-1:0];
        ADDR_TRESH1: m_tresh[1] = d.word[DW-1:0];
        ADDR_HYST0:  m_hyst[0]  = d.word[DW-1:0];
        ADDR_HYST1:  m_hyst[1]  = d.word[DW-1:0];
        ADDR_DLY0:   m_dly[0]   = d.word;
        ADDR_DLY1:   m_dly[1]   = d.word;
        ADDR_DEC0:   m_dec[0]   = d.word[DEC_W-1:0];
        ADDR_DEC1:   m_dec[1]   = d.word[DEC_W-1:0];
        default: begin
          for (int ch = 0; ch < N_CH; ch++) begin
            ln  = d.lane[ch];
            nib = ln[TRG_SRC_W-1:0];
            if (addr == ADDR_CTRL) begin
              x_arm[ch] = ln[CTRL_ARM_BIT];
              x_rst[ch] = ln[CTRL_RST_BIT];
              // a zero lane keeps the channel's mode
              if (ln != 8'h00) begin
                m_keep[ch]  = ln[CTRL_KEEP_BIT];
                m_indep[ch] = ln[CTRL_INDEP_BIT];
              end
            end
            if (addr == ADDR_TRG_SRC) begin
              x_sw[ch]  = (nib == TRG_SW_CODE);
              x_new[ch] = (nib != '0);
              if (nib != '0)
                m_trg[ch] = nib;
            end
            if (addr == ADDR_AVG_EN)
              m_avg[ch] = ln[0];
            if (addr == ADDR_TRIG_CLR)
              x_clr[ch] = ln[0];
          end
        end
      endcase
    end
  endtask

`endif

// ==== sim/tb_scope_cfg.sv ====
/*
 * testbench for the scope configuration block
 * random bus accesses and status inputs, reference model,
 * typed compare tasks, cycle timeout and summary
 */
`timescale 1ns/1ps

module tb_scope_cfg
  import scope_pkg::*;
();

  localparam int N_CYC      = 680;
  // reset, stimulus and drain with ample slack
  localparam int MAX_CYCLES = 2000;

  logic                      adc_clk_i = 1'b0;
  logic                      adc_rstn_i;
  logic [ADDR_W-1:0]         sys_addr_i;
  logic [31:0]               sys_wdata_i;
  logic                      sys_wen_i;
  logic                      sys_ren_i;
  logic [31:0]               sys_rdata_o;
  logic                      sys_ack_o;
  logic                      sys_err_o;
  logic [31:0]               adc_state_i;
  logic [31:0]               trg_state_i;
  logic [N_CH-1:0][RSZ-1:0]  adc_wp_cur_i;
  logic [N_CH-1:0][RSZ-1:0]  adc_wp_trig_i;
  logic      [N_CH-1:0]      adc_arm_do_o;
  logic      [N_CH-1:0]      adc_rst_do_o;
  logic      [N_CH-1:0]      adc_trig_sw_o;
  logic      [N_CH-1:0]      trig_dis_clr_o;
  logic      [N_CH-1:0]      new_trg_src_o;
  logic      [N_CH-1:0]      adc_we_keep_o;
  logic      [N_CH-1:0]      indep_mode_o;
  trg_src_t  [N_CH-1:0]      trg_src_o;
  adc_word_t [N_CH-1:0]      set_tresh_o;
  adc_word_t [N_CH-1:0]      set_hyst_o;
  dly_t      [N_CH-1:0]      set_dly_o;
  dec_t      [N_CH-1:0]      set_dec_o;
  logic      [N_CH-1:0]      set_dec1_o;
  logic      [N_CH-1:0]      set_avg_en_o;

  integer            seed;
  int                errors = 0;
  int                checks = 0;
  int                cycles = 0;
  logic              p1_wr;
  logic              p1_rd;
  logic              p2_wr;
  logic              p2_rd;
  logic [ADDR_W-1:0] p1_addr;
  logic [ADDR_W-1:0] p2_addr;
  sys_word_u         p1_data;
  sys_word_u         p2_data;
  logic [ADDR_W-1:0] addr_tab [20];

  `include "scope_ref_model.svh"

  scope_cfg u_scope_cfg (.*);

  always #10 adc_clk_i = ~adc_clk_i;

  always @(posedge adc_clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL t=%0t %s exp=%h act=%h", $time, name, exp, act);
    end
  endtask

  task automatic check_adc(input string name, input adc_word_t exp, input adc_word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL t=%0t %s exp=%0d act=%0d", $time, name, exp, act);
    end
  endtask

  task automatic check_dec(input string name, input dec_t exp, input dec_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL t=%0t %s exp=%h act=%h", $time, name, exp, act);
    end
  endtask

  task automatic check_dly(input string name, input dly_t exp, input dly_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL t=%0t %s exp=%h act=%h", $time, name, exp, act);
    end
  endtask

  task automatic check_trg(input string name, input trg_src_t exp, input trg_src_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL t=%0t %s exp=%h act=%h", $time, name, exp, act);
    end
  endtask

  task automatic check_bits(input string name, input logic [N_CH-1:0] exp,
                            input logic [N_CH-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL t=%0t %s exp=%b act=%b", $time, name, exp, act);
    end
  endtask

  // one access or idle cycle, plus fresh status and pointer inputs
  task automatic drive_access(input logic allow);
    logic [31:0]       r;
    logic [31:0]       d;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] a;
    r  = $random(seed);
    d  = $random(seed);
    wr = 1'b0;
    rd = 1'b0;
    // about one cycle in eight stays idle
    if (allow && r[2:0] != 3'd0) begin
      wr = r[3];
      rd = ~r[3];
    end
    if (r[7:4] == 4'd0)
      a = r[31:12] & 20'hFFFFC;
    else
      a = addr_tab[5'(r[15:8] % 8'd20)];
    case (r[17:16])
      2'd0: ;
      2'd1: d = d & 32'h0000_2b2b;
      2'd2: d = 32'd1;
      default: d = d & 32'h0000_0f0f;
    endcase
    sys_wen_i   <= wr;
    sys_ren_i   <= rd;
    sys_addr_i  <= a;
    sys_wdata_i <= d;
    adc_state_i <= $random(seed);
    trg_state_i <= $random(seed);
    r = $random(seed);
    adc_wp_cur_i <= {r[29:16], r[13:0]};
    r = $random(seed);
    adc_wp_trig_i <= {r[29:16], r[13:0]};
    p1_wr   = wr;
    p1_rd   = rd;
    p1_addr = a;
    p1_data.word = d;
  endtask

  task automatic compare_outputs();
    int s;
    if (sys_ack_o !== x_ack) begin
      errors++;
      if (x_ack)
        $display("missing ack at t=%0t for the access two cycles earlier", $time);
      else
        $display("extra ack at t=%0t with no access two cycles earlier", $time);
    end
    if (sys_err_o !== 1'b0) begin
      errors++;
      $display("FAIL t=%0t sys_err_o exp=0 act=%b", $time, sys_err_o);
    end
    if (x_ack && x_rd)
      check_word("sys_rdata_o", x_rdata, sys_rdata_o);
    check_bits("adc_arm_do_o", follow(x_arm), adc_arm_do_o);
    check_bits("adc_rst_do_o", follow(x_rst), adc_rst_do_o);
    check_bits("adc_trig_sw_o", follow(x_sw), adc_trig_sw_o);
    check_bits("new_trg_src_o", follow(x_new), new_trg_src_o);
    check_bits("trig_dis_clr_o", follow(x_clr), trig_dis_clr_o);
    check_bits("adc_we_keep_o", follow(m_keep), adc_we_keep_o);
    check_bits("indep_mode_o", m_indep, indep_mode_o);
    check_bits("set_avg_en_o", follow(m_avg), set_avg_en_o);
    check_bits("set_dec1_o", exp_dec1(), set_dec1_o);
    for (int ch = 0; ch < N_CH; ch++) begin
      s = src_ch(ch);
      check_adc($sformatf("set_tresh_o[%0d]", ch), m_tresh[ch], set_tresh_o[ch]);
      check_adc($sformatf("set_hyst_o[%0d]", ch), m_hyst[ch], set_hyst_o[ch]);
      check_dly($sformatf("set_dly_o[%0d]", ch), m_dly[s], set_dly_o[ch]);
      check_dec($sformatf("set_dec_o[%0d]", ch), m_dec[s], set_dec_o[ch]);
      check_trg($sformatf("trg_src_o[%0d]", ch), m_trg[s], trg_src_o[ch]);
    end
  endtask

  initial begin
    seed = 32'hbab4_88b9;
    addr_tab = '{ADDR_CTRL, ADDR_TRG_SRC, ADDR_TRESH0, ADDR_TRESH1, ADDR_DLY0,
                 ADDR_DEC0, ADDR_DLY1, ADDR_DEC1, ADDR_HYST0, ADDR_HYST1, ADDR_AVG_EN,
                 ADDR_WP_CUR0, ADDR_WP_TRIG0, ADDR_WP_CUR1, ADDR_WP_TRIG1, ADDR_TRIG_CLR,
                 20'h0002C, 20'h00030, 20'h00098, 20'h00120};
    adc_rstn_i    <= 1'b0;
    sys_wen_i     <= 1'b0;
    sys_ren_i     <= 1'b0;
    sys_addr_i    <= '0;
    sys_wdata_i   <= '0;
    adc_state_i   <= '0;
    trg_state_i   <= '0;
    adc_wp_cur_i  <= '0;
    adc_wp_trig_i <= '0;
    model_reset();
    p1_wr   = 1'b0;
    p1_rd   = 1'b0;
    p1_addr = '0;
    p1_data = '0;
    p2_wr   = 1'b0;
    p2_rd   = 1'b0;
    p2_addr = '0;
    p2_data = '0;
    repeat (8) @(posedge adc_clk_i);
    adc_rstn_i <= 1'b1;
    // two extra cycles let the last accesses drain
    for (int i = 0; i < N_CYC + 2; i++) begin
      @(posedge adc_clk_i);
      // p2 holds the access driven two edges back, the one whose results show now
      model_access(p2_wr, p2_rd, p2_addr, p2_data, adc_state_i, trg_state_i,
                   adc_wp_cur_i, adc_wp_trig_i);
      p2_wr   = p1_wr;
      p2_rd   = p1_rd;
      p2_addr = p1_addr;
      p2_data = p1_data;
      drive_access(i < N_CYC);
      @(negedge adc_clk_i);
      compare_outputs();
    end
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== scope_cfg.f ====
+incdir+sim
common/scope_pkg.sv
common/scope_access_if.sv
common/scope_cfg_if.sv
design/scope_decode.sv
scope_regs/scope_regs.sv
design/scope_readback.sv
design/scope_cfg.sv
sim/tb_scope_cfg.sv

// ==== Makefile ====
TOP := tb_scope_cfg

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f scope_cfg.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f scope_cfg.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log
